//--- include/i2c_master_consts.svh
`ifndef I2C_MASTER_CONSTS_SVH
`define I2C_MASTER_CONSTS_SVH

// slave address and data byte widths
`define I2C_ADDR_W 7
`define I2C_DATA_W 8

// prescale input and delay counter width
`define I2C_PRESCALE_W 16
`define I2C_BIT_CNT_W 4

`endif

//--- logic/i2c_pkg.sv
package i2c_pkg;

    // operations from byte controller to bit engine
    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_t;

    // byte level command sequencer
    typedef enum logic [3:0] {
        CTRL_IDLE,
        CTRL_START_WAIT,
        CTRL_START,
        CTRL_ADDRESS,
        CTRL_ADDR_ACK,
        CTRL_WRITE,
        CTRL_WRITE_ACK,
        CTRL_READ,
        CTRL_READ_NACK,
        CTRL_STOP
    } ctrl_state_t;

    // bit waveform generator, quarter period steps
    typedef enum logic [4:0] {
        IDLE, ACTIVE,
        START_1, START_2,
        WRITE_1, WRITE_2, WRITE_3,
        READ_1, READ_2, READ_3, READ_4,
        STOP_1, STOP_2, STOP_3
    } phy_state_t;

endpackage

//--- logic/i2c_bit_if.sv
`timescale 1ns/1ps

// one bit operation per valid & ready cycle
interface i2c_bit_if;
    i2c_pkg::bit_op_t op;
    // level to send on a write op
    logic tx_bit;
    logic valid;
    // engine idle and able to take the next op
    logic ready;
    // last bit sampled by a read op
    logic rx_bit;

    modport ctrl (
        output op,
        output tx_bit,
        output valid,
        input  ready,
        input  rx_bit
    );

    modport phy (
        input  op,
        input  tx_bit,
        input  valid,
        output ready,
        output rx_bit
    );
endinterface

//--- logic/i2c_line_monitor.sv
`timescale 1ns/1ps

module i2c_line_monitor (
    input  logic clk,
    input  logic rst,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_sync,
    output logic sda_sync,
    output logic bus_active
);

    // first sync stage
    logic scl_meta;
    logic sda_meta;
    // previous synced sda for edge detect
    logic sda_last;
    logic start_seen;
    logic stop_seen;

    // sda edges while scl high mark start and stop
    assign start_seen = sda_last & ~sda_sync & scl_sync;
    assign stop_seen  = ~sda_last & sda_sync & scl_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            // released bus reads high
            scl_meta   <= 1'b1;
            sda_meta   <= 1'b1;
            scl_sync   <= 1'b1;
            sda_sync   <= 1'b1;
            sda_last   <= 1'b1;
            bus_active <= 1'b0;
        end else begin
            scl_meta <= scl_i;
            sda_meta <= sda_i;
            scl_sync <= scl_meta;
            sda_sync <= sda_meta;
            sda_last <= sda_sync;
            if (start_seen) begin
                bus_active <= 1'b1;
            end else if (stop_seen) begin
                bus_active <= 1'b0;
            end
        end
    end

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "i2c_master_consts.svh"

module i2c_bit_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`I2C_PRESCALE_W-1:0] prescale,
    input  logic                       scl_sync,
    input  logic                       sda_sync,
    i2c_bit_if.phy                     bit_bus,
    output logic                       scl_o,
    output logic                       sda_o
);

    i2c_pkg::phy_state_t state_reg, state_next;
    logic [`I2C_PRESCALE_W-1:0] delay_reg, delay_next;
    // set while released scl is still held low by a slave
    logic scl_wait_reg, scl_wait_next;
    logic scl_reg, scl_next;
    logic sda_reg, sda_next;
    logic rx_reg, rx_next;

    assign scl_o = scl_reg;
    assign sda_o = sda_reg;
    assign bit_bus.rx_bit = rx_reg;

    // only between waveforms, nothing pending
    assign bit_bus.ready = (state_reg == i2c_pkg::IDLE || state_reg == i2c_pkg::ACTIVE) &&
                           !scl_wait_reg && delay_reg == '0;

    always_comb begin
        state_next    = state_reg;
        delay_next    = delay_reg;
        scl_wait_next = scl_wait_reg;
        scl_next      = scl_reg;
        sda_next      = sda_reg;
        rx_next       = rx_reg;

        if (scl_wait_reg) begin
            // clock stretch, count high phase only once scl reads high
            scl_wait_next = scl_reg & ~scl_sync;
        end else if (delay_reg != '0) begin
            delay_next = delay_reg - 1'b1;
        end else begin
            case (state_reg)
                i2c_pkg::IDLE, i2c_pkg::ACTIVE: begin
                    if (bit_bus.valid) begin
                        delay_next = prescale;
                        case (bit_bus.op)
                            i2c_pkg::BIT_START: begin
                                // sda falls while scl high
                                sda_next   = 1'b0;
                                state_next = i2c_pkg::START_1;
                            end
                            i2c_pkg::BIT_WRITE: begin
                                sda_next   = bit_bus.tx_bit;
                                state_next = i2c_pkg::WRITE_1;
                            end
                            i2c_pkg::BIT_READ: begin
                                // release sda for the slave
                                sda_next   = 1'b1;
                                state_next = i2c_pkg::READ_1;
                            end
                            default: begin
                                sda_next   = 1'b0;
                                state_next = i2c_pkg::STOP_1;
                            end
                        endcase
                    end
                end
                i2c_pkg::START_1: begin
                    scl_next   = 1'b0;
                    delay_next = prescale;
                    state_next = i2c_pkg::START_2;
                end
                i2c_pkg::START_2: begin
                    state_next = i2c_pkg::ACTIVE;
                end
                i2c_pkg::WRITE_1: begin
                    // high phase is two steps long
                    scl_next      = 1'b1;
                    scl_wait_next = 1'b1;
                    delay_next    = {prescale[`I2C_PRESCALE_W-2:0], 1'b0};
                    state_next    = i2c_pkg::WRITE_2;
                end
                i2c_pkg::WRITE_2: begin
                    scl_next   = 1'b0;
                    delay_next = prescale;
                    state_next = i2c_pkg::WRITE_3;
                end
                i2c_pkg::WRITE_3: begin
                    state_next = i2c_pkg::ACTIVE;
                end
                i2c_pkg::READ_1: begin
                    scl_next      = 1'b1;
                    scl_wait_next = 1'b1;
                    delay_next    = prescale;
                    state_next    = i2c_pkg::READ_2;
                end
                i2c_pkg::READ_2: begin
                    // middle of the high phase
                    rx_next    = sda_sync;
                    delay_next = prescale;
                    state_next = i2c_pkg::READ_3;
                end
                i2c_pkg::READ_3: begin
                    scl_next   = 1'b0;
                    delay_next = prescale;
                    state_next = i2c_pkg::READ_4;
                end
                i2c_pkg::READ_4: begin
                    state_next = i2c_pkg::ACTIVE;
                end
                i2c_pkg::STOP_1: begin
                    scl_next      = 1'b1;
                    scl_wait_next = 1'b1;
                    delay_next    = prescale;
                    state_next    = i2c_pkg::STOP_2;
                end
                i2c_pkg::STOP_2: begin
                    // sda rises while scl high
                    sda_next   = 1'b1;
                    delay_next = prescale;
                    state_next = i2c_pkg::STOP_3;
                end
                default: begin
                    state_next = i2c_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg    <= i2c_pkg::IDLE;
            delay_reg    <= '0;
            scl_wait_reg <= 1'b0;
            scl_reg      <= 1'b1;
            sda_reg      <= 1'b1;
        end else begin
            state_reg    <= state_next;
            delay_reg    <= delay_next;
            scl_wait_reg <= scl_wait_next;
            scl_reg      <= scl_next;
            sda_reg      <= sda_next;
        end
        rx_reg <= rx_next;
    end

endmodule

//--- logic/i2c_byte_ctrl.sv
`timescale 1ns/1ps
`include "i2c_master_consts.svh"

module i2c_byte_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`I2C_ADDR_W-1:0] cmd_address,
    input  logic                   cmd_read,
    input  logic [`I2C_DATA_W-1:0] cmd_data,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output logic [`I2C_DATA_W-1:0] data_out,
    output logic                   data_out_valid,
    input  logic                   data_out_ready,
    output logic                   busy,
    output logic                   missed_ack,
    input  logic                   bus_active,
    i2c_bit_if.ctrl                bit_bus
);

    i2c_pkg::ctrl_state_t state_reg, state_next;
    logic [`I2C_ADDR_W-1:0] addr_reg, addr_next;
    logic mode_read_reg, mode_read_next;
    // write byte out, read byte in
    logic [`I2C_DATA_W-1:0] data_reg, data_next;
    logic [`I2C_BIT_CNT_W-1:0] bit_count_reg, bit_count_next;
    logic cmd_ready_next;
    logic [`I2C_DATA_W-1:0] data_out_next;
    logic data_out_valid_next;
    logic missed_ack_next;
    logic busy_next;

    always_comb begin
        state_next          = state_reg;
        addr_next           = addr_reg;
        mode_read_next      = mode_read_reg;
        data_next           = data_reg;
        bit_count_next      = bit_count_reg;
        data_out_next       = data_out;
        data_out_valid_next = data_out_valid & ~data_out_ready;
        cmd_ready_next      = 1'b0;
        missed_ack_next     = 1'b0;
        bit_bus.op          = i2c_pkg::BIT_WRITE;
        bit_bus.tx_bit      = 1'b0;
        bit_bus.valid       = 1'b0;

        // hold while the engine runs a waveform
        if (bit_bus.ready) begin
            case (state_reg)
                i2c_pkg::CTRL_IDLE: begin
                    // no new command until read data is taken
                    cmd_ready_next = ~data_out_valid_next;
                    if (cmd_ready && cmd_valid) begin
                        addr_next      = cmd_address;
                        mode_read_next = cmd_read;
                        data_next      = cmd_data;
                        cmd_ready_next = 1'b0;
                        state_next     = i2c_pkg::CTRL_START_WAIT;
                    end
                end
                i2c_pkg::CTRL_START_WAIT: begin
                    // another master owns the bus
                    if (!bus_active) begin
                        state_next = i2c_pkg::CTRL_START;
                    end
                end
                i2c_pkg::CTRL_START: begin
                    bit_bus.op     = i2c_pkg::BIT_START;
                    bit_bus.valid  = 1'b1;
                    bit_count_next = `I2C_BIT_CNT_W'(`I2C_ADDR_W + 1);
                    state_next     = i2c_pkg::CTRL_ADDRESS;
                end
                i2c_pkg::CTRL_ADDRESS: begin
                    bit_bus.valid  = 1'b1;
                    bit_count_next = bit_count_reg - 1'b1;
                    if (bit_count_reg > 1) begin
                        // address msb first
                        bit_bus.tx_bit = addr_reg[bit_count_reg - 2];
                    end else if (bit_count_reg == 1) begin
                        bit_bus.tx_bit = mode_read_reg;
                    end else begin
                        // slave ack slot
                        bit_bus.op = i2c_pkg::BIT_READ;
                        state_next = i2c_pkg::CTRL_ADDR_ACK;
                    end
                end
                i2c_pkg::CTRL_ADDR_ACK: begin
                    missed_ack_next = bit_bus.rx_bit;
                    bit_count_next  = `I2C_BIT_CNT_W'(`I2C_DATA_W);
                    state_next      = mode_read_reg ? i2c_pkg::CTRL_READ : i2c_pkg::CTRL_WRITE;
                end
                i2c_pkg::CTRL_WRITE: begin
                    bit_bus.valid  = 1'b1;
                    bit_count_next = bit_count_reg - 1'b1;
                    if (bit_count_reg > 0) begin
                        bit_bus.tx_bit = data_reg[bit_count_reg - 1];
                    end else begin
                        bit_bus.op = i2c_pkg::BIT_READ;
                        state_next = i2c_pkg::CTRL_WRITE_ACK;
                    end
                end
                i2c_pkg::CTRL_WRITE_ACK: begin
                    missed_ack_next = bit_bus.rx_bit;
                    state_next      = i2c_pkg::CTRL_STOP;
                end
                i2c_pkg::CTRL_READ: begin
                    // first shift drops the ack bit
                    data_next      = {data_reg[`I2C_DATA_W-2:0], bit_bus.rx_bit};
                    bit_count_next = bit_count_reg - 1'b1;
                    if (bit_count_reg > 0) begin
                        bit_bus.op    = i2c_pkg::BIT_READ;
                        bit_bus.valid = 1'b1;
                    end else begin
                        // byte complete, present before nack
                        data_out_next       = data_next;
                        data_out_valid_next = 1'b1;
                        state_next          = i2c_pkg::CTRL_READ_NACK;
                    end
                end
                i2c_pkg::CTRL_READ_NACK: begin
                    // single byte read, master nack
                    bit_bus.tx_bit = 1'b1;
                    bit_bus.valid  = 1'b1;
                    state_next     = i2c_pkg::CTRL_STOP;
                end
                i2c_pkg::CTRL_STOP: begin
                    bit_bus.op    = i2c_pkg::BIT_STOP;
                    bit_bus.valid = 1'b1;
                    state_next    = i2c_pkg::CTRL_IDLE;
                end
                default: begin
                    state_next = i2c_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    // covers the issue cycle of the final stop too
    assign busy_next = (state_next != i2c_pkg::CTRL_IDLE) || !bit_bus.ready || bit_bus.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= i2c_pkg::CTRL_IDLE;
            cmd_ready      <= 1'b0;
            data_out_valid <= 1'b0;
            busy           <= 1'b0;
            missed_ack     <= 1'b0;
        end else begin
            state_reg      <= state_next;
            cmd_ready      <= cmd_ready_next;
            data_out_valid <= data_out_valid_next;
            busy           <= busy_next;
            missed_ack     <= missed_ack_next;
        end
        addr_reg      <= addr_next;
        mode_read_reg <= mode_read_next;
        data_reg      <= data_next;
        bit_count_reg <= bit_count_next;
        data_out      <= data_out_next;
    end

endmodule

//--- logic/i2c_master.sv
`timescale 1ns/1ps
`include "i2c_master_consts.svh"

module i2c_master (
    input  logic                       clk,
    input  logic                       rst,
    // host command
    input  logic [`I2C_ADDR_W-1:0]     cmd_address,
    input  logic                       cmd_read,
    input  logic [`I2C_DATA_W-1:0]     cmd_data,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    // read data
    output logic [`I2C_DATA_W-1:0]     data_out,
    output logic                       data_out_valid,
    input  logic                       data_out_ready,
    // open drain lines, output high releases
    input  logic                       scl_i,
    output logic                       scl_o,
    input  logic                       sda_i,
    output logic                       sda_o,
    // status
    output logic                       busy,
    output logic                       bus_active,
    output logic                       missed_ack,
    // quarter scl period in clk cycles
    input  logic [`I2C_PRESCALE_W-1:0] prescale
);

    logic scl_sync;
    logic sda_sync;

    i2c_bit_if bit_bus ();

    i2c_line_monitor i_line_monitor (
        .clk        (clk),
        .rst        (rst),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .scl_sync   (scl_sync),
        .sda_sync   (sda_sync),
        .bus_active (bus_active)
    );

    i2c_bit_engine i_bit_engine (
        .clk      (clk),
        .rst      (rst),
        .prescale (prescale),
        .scl_sync (scl_sync),
        .sda_sync (sda_sync),
        .bit_bus  (bit_bus.phy),
        .scl_o    (scl_o),
        .sda_o    (sda_o)
    );

    i2c_byte_ctrl i_byte_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cmd_address    (cmd_address),
        .cmd_read       (cmd_read),
        .cmd_data       (cmd_data),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy),
        .missed_ack     (missed_ack),
        .bus_active     (bus_active),
        .bit_bus        (bit_bus.ctrl)
    );

endmodule

//--- verification/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] own_address = 7'h50,
    parameter int         max_stretch = 8
) (
    input  logic clk,
    input  logic rst,
    // wired-and bus lines
    input  logic scl,
    input  logic sda,
    input  logic stretch_en,
    // low pulls the line down
    output logic scl_drive,
    output logic sda_drive
);

    localparam int s_idle = 0, s_addr = 1, s_addr_ack = 2, s_write = 3;
    localparam int s_write_ack = 4, s_read = 5, s_read_ack = 6;

    int state;
    int stretch_cnt;
    logic scl_q;
    logic sda_q;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    // the one storage register
    logic [7:0] mem;
    logic rw;

    always @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            stretch_cnt <= 0;
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            scl_drive <= 1'b1;
            sda_drive <= 1'b1;
            mem <= 8'h00;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (stretch_cnt != 0) begin
                stretch_cnt <= stretch_cnt - 1;
                if (stretch_cnt == 1) scl_drive <= 1'b1;
            end
            if (scl && scl_q && sda_q && !sda) begin
                // start condition
                state <= s_addr;
                bit_cnt <= 4'd0;
                sda_drive <= 1'b1;
            end else if (scl && scl_q && !sda_q && sda) begin
                // stop condition
                state <= s_idle;
                sda_drive <= 1'b1;
            end else if (scl && !scl_q) begin
                // rising scl, take in address or write bits
                if (state == s_addr || state == s_write) begin
                    shift <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (!scl && scl_q) begin
                // falling scl, hold low for a random time
                if (stretch_en) begin
                    scl_drive <= 1'b0;
                    stretch_cnt <= 1 + ($urandom % max_stretch);
                end
                case (state)
                    s_addr: if (bit_cnt == 4'd8) begin
                        if (shift[7:1] == own_address) begin
                            sda_drive <= 1'b0;
                            rw <= shift[0];
                            state <= s_addr_ack;
                        end else begin
                            state <= s_idle;
                        end
                    end
                    s_addr_ack: begin
                        bit_cnt <= rw ? 4'd1 : 4'd0;
                        // first read bit goes out right after the ack
                        sda_drive <= rw ? mem[7] : 1'b1;
                        state <= rw ? s_read : s_write;
                    end
                    s_write: if (bit_cnt == 4'd8) begin
                        mem <= shift;
                        sda_drive <= 1'b0;
                        state <= s_write_ack;
                    end
                    s_read: begin
                        if (bit_cnt == 4'd8) begin
                            // release for the master nack
                            sda_drive <= 1'b1;
                            state <= s_read_ack;
                        end else begin
                            sda_drive <= mem[7 - bit_cnt];
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    default: begin
                        sda_drive <= 1'b1;
                        state <= s_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- verification/tb_i2c_master.sv
`timescale 1ns/1ps
`include "i2c_master_consts.svh"

module tb_i2c_master;

    localparam logic [6:0] slave_addr = 7'h50;
    // long enough to outlast the master's scl low phase
    localparam int max_stretch = 32;
    localparam int prescale_val = 4;
    localparam int num_rows = 10;
    // cycles allowed for one transaction
    localparam int tr_limit = 40 * 4 * (prescale_val + 1 + max_stretch) * 2;
    localparam int kind_plain = 0, kind_foreign = 1, kind_hold = 2;

    logic clk;
    logic rst;
    logic [`I2C_ADDR_W-1:0] cmd_address;
    logic cmd_read;
    logic [`I2C_DATA_W-1:0] cmd_data;
    logic cmd_valid;
    logic cmd_ready;
    logic [`I2C_DATA_W-1:0] data_out;
    logic data_out_valid;
    logic data_out_ready;
    logic scl_o, sda_o, scl_line, sda_line;
    logic slave_scl, slave_sda, scl_tb, sda_tb;
    logic busy, bus_active, missed_ack;
    logic [`I2C_PRESCALE_W-1:0] prescale;
    logic stretch_en;
    int error_count;
    int pass_count;
    int fail_count;

    // stimulus table
    string row_name [num_rows];
    logic row_read [num_rows];
    logic [6:0] row_addr [num_rows];
    logic [7:0] row_wdata [num_rows];
    logic row_stretch [num_rows];
    int row_kind [num_rows];
    logic [7:0] row_exp_data [num_rows];
    int row_exp_miss [num_rows];

    // wired-and bus
    assign scl_line = scl_o & slave_scl & scl_tb;
    assign sda_line = sda_o & slave_sda & sda_tb;

    i2c_master i_dut (
        .clk(clk), .rst(rst),
        .cmd_address(cmd_address), .cmd_read(cmd_read), .cmd_data(cmd_data),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .data_out(data_out), .data_out_valid(data_out_valid),
        .data_out_ready(data_out_ready),
        .scl_i(scl_line), .scl_o(scl_o), .sda_i(sda_line), .sda_o(sda_o),
        .busy(busy), .bus_active(bus_active), .missed_ack(missed_ack),
        .prescale(prescale)
    );

    i2c_slave_model #(.own_address(slave_addr), .max_stretch(max_stretch)) i_slave (
        .clk(clk), .rst(rst), .scl(scl_line), .sda(sda_line),
        .stretch_en(stretch_en), .scl_drive(slave_scl), .sda_drive(slave_sda)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rows x 40 bits x 4 steps x worst step, doubled
    initial begin
        #(num_rows * 40 * 4 * (prescale_val + 1 + max_stretch) * 10 * 2);
        $display("watchdog expired, the run did not finish in time");
        $display("sim failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0h, actual %0h", what, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_row(input int i, input string name, input logic rd,
                           input logic [6:0] addr, input logic [7:0] wdata,
                           input logic str, input int kind, input logic [7:0] exp_data,
                           input int exp_miss);
        row_name[i] = name;
        row_read[i] = rd;
        row_addr[i] = addr;
        row_wdata[i] = wdata;
        row_stretch[i] = str;
        row_kind[i] = kind;
        row_exp_data[i] = exp_data;
        row_exp_miss[i] = exp_miss;
    endtask

    task automatic run_row(input int i);
        int cycles;
        int misses;
        int errors_before;
        logic got;
        logic held_done;
        logic [7:0] rd;
        logic [7:0] held;
        errors_before = error_count;
        misses = 0;
        got = 1'b0;
        held_done = 1'b0;
        rd = 8'h00;
        @(posedge clk);
        stretch_en <= row_stretch[i];
        data_out_ready <= (row_kind[i] != kind_hold);
        if (row_kind[i] == kind_foreign) begin
            // another master takes the bus with a start
            sda_tb <= 1'b0;
            repeat (8) @(posedge clk);
            check_value({row_name[i], " bus_active"}, 1, bus_active);
            // and clocks the bus low as its owner
            scl_tb <= 1'b0;
        end
        cmd_address <= row_addr[i];
        cmd_read <= row_read[i];
        cmd_data <= row_wdata[i];
        cmd_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(cmd_valid && cmd_ready) && cycles < tr_limit);
        cmd_valid <= 1'b0;
        if (row_kind[i] == kind_foreign) begin
            // master must keep off the bus
            repeat (100) begin
                @(posedge clk);
                check_value({row_name[i], " scl_o"}, 1, scl_o);
                check_value({row_name[i], " bus_active"}, 1, bus_active);
            end
            // stop from the other master, scl released first
            scl_tb <= 1'b1;
            repeat (8) @(posedge clk);
            sda_tb <= 1'b1;
        end
        cycles = 0;
        forever begin
            @(posedge clk);
            if (missed_ack) misses++;
            // busy spans the whole transaction
            if (!cmd_ready && !held_done) begin
                check_value({row_name[i], " busy during"}, 1, busy);
            end
            if (data_out_valid && data_out_ready) begin
                rd = data_out;
                got = 1'b1;
            end
            if (data_out_valid && !data_out_ready && !held_done) begin
                // back-pressure, output must stay put
                held = data_out;
                repeat (200) begin
                    @(posedge clk);
                    if (missed_ack) misses++;
                    check_value({row_name[i], " held data"}, held, data_out);
                    check_value({row_name[i], " held valid"}, 1, data_out_valid);
                    check_value({row_name[i], " cmd_ready"}, 0, cmd_ready);
                end
                data_out_ready <= 1'b1;
                held_done = 1'b1;
            end
            if (cmd_ready) break;
            cycles++;
            if (cycles > tr_limit) begin
                $display("test %s: cmd_ready did not return in time", row_name[i]);
                error_count++;
                break;
            end
        end
        check_value({row_name[i], " missed_ack"}, row_exp_miss[i], misses);
        check_value({row_name[i], " read taken"}, row_read[i], got);
        if (row_read[i]) begin
            check_value({row_name[i], " data"}, row_exp_data[i], rd);
        end
        check_value({row_name[i], " bus_active"}, 0, bus_active);
        check_value({row_name[i], " busy"}, 0, busy);
        if (error_count == errors_before) begin
            $display("test %s: ok", row_name[i]);
            pass_count++;
        end else begin
            $display("test %s: failed", row_name[i]);
            fail_count++;
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(60616));
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        rst = 1'b1;
        cmd_address = '0;
        cmd_read = 1'b0;
        cmd_data = '0;
        cmd_valid = 1'b0;
        data_out_ready = 1'b0;
        prescale = prescale_val;
        scl_tb = 1'b1;
        sda_tb = 1'b1;
        stretch_en = 1'b0;
        add_row(0, "wr_a5", 0, slave_addr, 8'hA5, 0, kind_plain, 8'h00, 0);
        add_row(1, "rd_a5", 1, slave_addr, 8'h00, 0, kind_plain, 8'hA5, 0);
        add_row(2, "wr_3c", 0, slave_addr, 8'h3C, 0, kind_plain, 8'h00, 0);
        add_row(3, "rd_3c", 1, slave_addr, 8'h00, 0, kind_plain, 8'h3C, 0);
        add_row(4, "rd_absent", 1, 7'h23, 8'h00, 0, kind_plain, 8'hFF, 1);
        add_row(5, "wr_stretch", 0, slave_addr, 8'h96, 1, kind_plain, 8'h00, 0);
        add_row(6, "rd_stretch", 1, slave_addr, 8'h00, 1, kind_plain, 8'h96, 0);
        add_row(7, "wr_foreign", 0, slave_addr, 8'hC3, 0, kind_foreign, 8'h00, 0);
        add_row(8, "rd_c3", 1, slave_addr, 8'h00, 0, kind_plain, 8'hC3, 0);
        add_row(9, "rd_hold", 1, slave_addr, 8'h00, 0, kind_hold, 8'hC3, 0);

        repeat (10) @(posedge clk);
        // reset values
        check_value("reset cmd_ready", 0, cmd_ready);
        check_value("reset busy", 0, busy);
        check_value("reset data_out_valid", 0, data_out_valid);
        check_value("reset missed_ack", 0, missed_ack);
        check_value("reset bus_active", 0, bus_active);
        check_value("reset scl_o", 1, scl_o);
        check_value("reset sda_o", 1, sda_o);
        rst <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cmd_ready && cycles < 5);
        if (!cmd_ready) begin
            $display("test reset: cmd_ready did not rise after reset");
            error_count++;
        end
        if (error_count == 0) begin
            $display("test reset: ok");
            pass_count++;
        end else begin
            $display("test reset: failed");
            fail_count++;
        end

        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end

        $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- i2c_master.f
+incdir+include
logic/i2c_pkg.sv
logic/i2c_bit_if.sv
logic/i2c_line_monitor.sv
logic/i2c_bit_engine.sv
logic/i2c_byte_ctrl.sv
logic/i2c_master.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_i2c_master \
    -f i2c_master.f -o sim_tb_i2c_master

out=$(./obj_dir/sim_tb_i2c_master)
echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -qx "sim passed"
